// ==== rtl/uce_fabric_pkg.sv ====
`default_nettype none

package uce_fabric_pkg;

  localparam int num_src       = 2;
  localparam int num_tgt       = 3;
  localparam int paddr_width   = 24;
  localparam int dword_width   = 64;
  localparam int dev_id_width  = 4;
  localparam int dev_id_lsb    = 16;
  localparam int dev_off_width = 16;
  localparam int core_id_width = 8;

  // Target slots on the arbiter side
  localparam int tgt_cfg   = 0;
  localparam int tgt_clint = 1;
  localparam int tgt_mem   = 2;

  typedef logic [paddr_width-1:0]     paddr_t;
  typedef logic [dword_width-1:0]     dword_t;
  typedef logic [dev_id_width-1:0]    dev_id_t;
  typedef logic [dev_off_width-1:0]   dev_off_t;
  typedef logic [core_id_width-1:0]   core_id_t;
  typedef logic [$clog2(num_src)-1:0] src_id_t;

  // Address map
  localparam paddr_t  dram_base_addr = 24'h80_0000;
  localparam dev_id_t clint_dev      = 4'd1;
  localparam dev_id_t cfg_dev        = 4'd2;
  localparam dev_id_t mem_dev        = 4'd3;

  localparam dev_off_t clint_msip_off     = 16'h0000;
  localparam dev_off_t clint_mtimecmp_off = 16'h4000;
  localparam dev_off_t clint_mtime_off    = 16'hBFF8;
  localparam dev_off_t cfg_freeze_off     = 16'h0000;
  localparam dev_off_t cfg_core_id_off    = 16'h0008;

  typedef enum logic {read, write} uce_op_e;

  typedef struct packed {
    uce_op_e op;
    paddr_t  addr;
    dword_t  data;
  } uce_cmd_s;

  typedef struct packed {
    uce_op_e op;
    paddr_t  addr;
    dword_t  data;
  } uce_resp_s;

  typedef struct packed {
    logic     freeze;
    core_id_t core_id;
  } cfg_bus_s;

endpackage

`default_nettype wire

// ==== rtl/uce_cmd_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module uce_cmd_arbiter
  import uce_fabric_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  uce_cmd_s  [num_src-1:0] src_cmd_i,
  input  logic      [num_src-1:0] src_cmd_v_i,
  output logic      [num_src-1:0] src_cmd_yumi_o,
  output uce_resp_s               src_resp_o,
  output logic      [num_src-1:0] src_resp_v_o,
  input  logic      [num_src-1:0] src_resp_ready_and_i,
  output uce_cmd_s                dev_cmd_o,
  output logic      [num_tgt-1:0] dev_cmd_v_o,
  input  logic      [num_tgt-1:0] dev_cmd_ready_and_i,
  input  uce_resp_s [num_tgt-1:0] dev_resp_i,
  input  logic      [num_tgt-1:0] dev_resp_v_i,
  output logic      [num_tgt-1:0] dev_resp_ready_and_o
);

  typedef enum logic [1:0] {idle, issue, wait_resp, respond} arb_state_e;

  arb_state_e         state_r;
  src_id_t            grant_src_r;
  src_id_t            pick;
  logic [num_tgt-1:0] dst_r;
  logic [num_tgt-1:0] pick_dst;
  logic               grant_v;
  uce_cmd_s           cmd_r;
  uce_resp_s          resp_r;
  uce_resp_s          dev_resp_sel;
  logic               dev_resp_hit;

  // One-hot target select that is all zero for loopback
  function automatic logic [num_tgt-1:0] decode_dst(paddr_t addr);
    logic               is_local;
    dev_id_t            dev;
    logic [num_tgt-1:0] dst;
    is_local       = (addr < dram_base_addr);
    dev            = addr[dev_id_lsb +: dev_id_width];
    dst            = '0;
    dst[tgt_mem]   = ~is_local | (dev == mem_dev);
    dst[tgt_cfg]   = is_local & (dev == cfg_dev);
    dst[tgt_clint] = is_local & (dev == clint_dev);
    return dst;
  endfunction

  assign grant_v  = (state_r == idle) & (|src_cmd_v_i);
  assign pick_dst = decode_dst(src_cmd_i[pick].addr);

  // Round robin between the two sources
  always_comb
  begin
    if (&src_cmd_v_i)
      pick = ~grant_src_r;
    else
      pick = src_cmd_v_i[1];
  end

  always_comb
  begin
    src_cmd_yumi_o = '0;
    src_resp_v_o   = '0;
    src_cmd_yumi_o[pick]      = grant_v;
    src_resp_v_o[grant_src_r] = (state_r == respond);
  end

  always_comb
  begin
    dev_resp_sel = '0;
    dev_resp_hit = 1'b0;
    for (int i = 0; i < num_tgt; i++)
    begin
      if (dst_r[i])
      begin
        dev_resp_sel = dev_resp_i[i];
        dev_resp_hit = dev_resp_v_i[i];
      end
    end
  end

  assign dev_cmd_o            = cmd_r;
  assign dev_cmd_v_o          = (state_r == issue) ? dst_r : '0;
  assign dev_resp_ready_and_o = (state_r == wait_resp) ? dst_r : '0;
  assign src_resp_o           = resp_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r     <= idle;
      grant_src_r <= '1;
      dst_r       <= '0;
    end
    else
    begin
      case (state_r)
        idle:
          if (grant_v)
          begin
            grant_src_r <= pick;
            dst_r       <= pick_dst;
            state_r     <= (|pick_dst) ? issue : respond;
          end
        issue:
          if (|(dev_cmd_ready_and_i & dst_r))
            state_r <= wait_resp;
        wait_resp:
          if (dev_resp_hit)
            state_r <= respond;
        respond:
          if (src_resp_ready_and_i[grant_src_r])
            state_r <= idle;
        default:
          state_r <= idle;
      endcase
    end
  end

  // The loopback answer is loaded at grant and replaced by a target response
  always_ff @(posedge clk_i)
  begin
    if (grant_v)
    begin
      cmd_r  <= src_cmd_i[pick];
      resp_r <= '{op: src_cmd_i[pick].op, addr: src_cmd_i[pick].addr, data: '0};
    end
    else if ((state_r == wait_resp) && dev_resp_hit)
      resp_r <= dev_resp_sel;
  end

endmodule

`default_nettype wire

// ==== rtl/uce_cfg_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module uce_cfg_regs
  import uce_fabric_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  uce_cmd_s  cmd_i,
  input  logic      cmd_v_i,
  output logic      cmd_ready_and_o,
  output uce_resp_s resp_o,
  output logic      resp_v_o,
  input  logic      resp_ready_and_i,
  output cfg_bus_s  cfg_bus_o
);

  dev_off_t  off;
  logic      cmd_fire;
  logic      wr_en;
  logic      freeze_r;
  core_id_t  core_id_r;
  dword_t    rd_data;
  uce_resp_s resp_r;
  logic      resp_v_r;

  assign cmd_ready_and_o = 1'b1;
  assign cmd_fire        = cmd_v_i & cmd_ready_and_o;
  assign off             = cmd_i.addr[dev_off_width-1:0];
  assign wr_en           = cmd_fire & (cmd_i.op == write);

  always_comb
  begin
    case (off)
      cfg_freeze_off:  rd_data = dword_t'(freeze_r);
      cfg_core_id_off: rd_data = dword_t'(core_id_r);
      default:         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      resp_v_r  <= 1'b0;
      freeze_r  <= 1'b1;
      core_id_r <= '0;
    end
    else
    begin
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_ready_and_i)
        resp_v_r <= 1'b0;
      if (wr_en && (off == cfg_freeze_off))
        freeze_r <= cmd_i.data[0];
      if (wr_en && (off == cfg_core_id_off))
        core_id_r <= cmd_i.data[core_id_width-1:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
      resp_r <= '{op: cmd_i.op, addr: cmd_i.addr, data: wr_en ? '0 : rd_data};
  end

  assign resp_o    = resp_r;
  assign resp_v_o  = resp_v_r;
  assign cfg_bus_o = '{freeze: freeze_r, core_id: core_id_r};

endmodule

`default_nettype wire

// ==== rtl/uce_clint.sv ====
`timescale 1ns/1ns
`default_nettype none

module uce_clint
  import uce_fabric_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  uce_cmd_s  cmd_i,
  input  logic      cmd_v_i,
  output logic      cmd_ready_and_o,
  output uce_resp_s resp_o,
  output logic      resp_v_o,
  input  logic      resp_ready_and_i,
  output logic      timer_irq_o,
  output logic      software_irq_o
);

  dev_off_t  off;
  logic      cmd_fire;
  logic      wr_en;
  dword_t    mtime_r;
  dword_t    mtimecmp_r;
  logic      msip_r;
  dword_t    rd_data;
  uce_resp_s resp_r;
  logic      resp_v_r;

  assign cmd_ready_and_o = 1'b1;
  assign cmd_fire        = cmd_v_i & cmd_ready_and_o;
  assign off             = cmd_i.addr[dev_off_width-1:0];
  assign wr_en           = cmd_fire & (cmd_i.op == write);

  always_comb
  begin
    case (off)
      clint_msip_off:     rd_data = dword_t'(msip_r);
      clint_mtimecmp_off: rd_data = mtimecmp_r;
      clint_mtime_off:    rd_data = mtime_r;
      default:            rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      resp_v_r   <= 1'b0;
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
    end
    else
    begin
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_ready_and_i)
        resp_v_r <= 1'b0;

      // A write to mtime takes priority over the tick
      if (wr_en && (off == clint_mtime_off))
        mtime_r <= cmd_i.data;
      else
        mtime_r <= mtime_r + 1'b1;

      if (wr_en && (off == clint_mtimecmp_off))
        mtimecmp_r <= cmd_i.data;
      if (wr_en && (off == clint_msip_off))
        msip_r <= cmd_i.data[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
      resp_r <= '{op: cmd_i.op, addr: cmd_i.addr, data: wr_en ? '0 : rd_data};
  end

  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

endmodule

`default_nettype wire

// ==== rtl/uce_unicore_lite.sv ====
`timescale 1ns/1ns
`default_nettype none

module uce_unicore_lite
  import uce_fabric_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  uce_cmd_s  [num_src-1:0] src_cmd_i,
  input  logic      [num_src-1:0] src_cmd_v_i,
  output logic      [num_src-1:0] src_cmd_yumi_o,
  output uce_resp_s               src_resp_o,
  output logic      [num_src-1:0] src_resp_v_o,
  input  logic      [num_src-1:0] src_resp_ready_and_i,
  output uce_cmd_s                mem_cmd_o,
  output logic                    mem_cmd_v_o,
  input  logic                    mem_cmd_ready_and_i,
  input  uce_resp_s               mem_resp_i,
  input  logic                    mem_resp_v_i,
  output logic                    mem_resp_ready_and_o,
  output cfg_bus_s                cfg_bus_o,
  output logic                    timer_irq_o,
  output logic                    software_irq_o
);

  uce_cmd_s                dev_cmd_lo;
  logic      [num_tgt-1:0] dev_cmd_v_lo;
  logic      [num_tgt-1:0] dev_cmd_ready_and_li;
  uce_resp_s [num_tgt-1:0] dev_resp_li;
  logic      [num_tgt-1:0] dev_resp_v_li;
  logic      [num_tgt-1:0] dev_resp_ready_and_lo;

  uce_cmd_arbiter arb
  (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .src_cmd_i            (src_cmd_i),
    .src_cmd_v_i          (src_cmd_v_i),
    .src_cmd_yumi_o       (src_cmd_yumi_o),
    .src_resp_o           (src_resp_o),
    .src_resp_v_o         (src_resp_v_o),
    .src_resp_ready_and_i (src_resp_ready_and_i),
    .dev_cmd_o            (dev_cmd_lo),
    .dev_cmd_v_o          (dev_cmd_v_lo),
    .dev_cmd_ready_and_i  (dev_cmd_ready_and_li),
    .dev_resp_i           (dev_resp_li),
    .dev_resp_v_i         (dev_resp_v_li),
    .dev_resp_ready_and_o (dev_resp_ready_and_lo)
  );

  uce_cfg_regs cfg
  (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cmd_i            (dev_cmd_lo),
    .cmd_v_i          (dev_cmd_v_lo[tgt_cfg]),
    .cmd_ready_and_o  (dev_cmd_ready_and_li[tgt_cfg]),
    .resp_o           (dev_resp_li[tgt_cfg]),
    .resp_v_o         (dev_resp_v_li[tgt_cfg]),
    .resp_ready_and_i (dev_resp_ready_and_lo[tgt_cfg]),
    .cfg_bus_o        (cfg_bus_o)
  );

  uce_clint clint
  (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cmd_i            (dev_cmd_lo),
    .cmd_v_i          (dev_cmd_v_lo[tgt_clint]),
    .cmd_ready_and_o  (dev_cmd_ready_and_li[tgt_clint]),
    .resp_o           (dev_resp_li[tgt_clint]),
    .resp_v_o         (dev_resp_v_li[tgt_clint]),
    .resp_ready_and_i (dev_resp_ready_and_lo[tgt_clint]),
    .timer_irq_o      (timer_irq_o),
    .software_irq_o   (software_irq_o)
  );

  // External memory sits in the last target slot
  assign mem_cmd_o                     = dev_cmd_lo;
  assign mem_cmd_v_o                   = dev_cmd_v_lo[tgt_mem];
  assign dev_cmd_ready_and_li[tgt_mem] = mem_cmd_ready_and_i;
  assign dev_resp_li[tgt_mem]          = mem_resp_i;
  assign dev_resp_v_li[tgt_mem]        = mem_resp_v_i;
  assign mem_resp_ready_and_o          = dev_resp_ready_and_lo[tgt_mem];

endmodule

`default_nettype wire

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_checker
  import uce_fabric_pkg::*;
(
  input  logic               clk_i,
  input  logic [num_src-1:0] yumi_i,
  input  uce_resp_s          resp_i,
  input  logic [num_src-1:0] resp_v_i,
  input  logic [num_src-1:0] resp_ready_and_i,
  input  cfg_bus_s           cfg_bus_i,
  input  logic               timer_irq_i,
  input  logic               software_irq_i
);

  typedef struct packed {
    src_id_t   src;
    uce_resp_s resp;
  } expect_s;

  src_id_t            grant_q [$];
  expect_s            resp_q [$];
  expect_s            cur;
  src_id_t            cur_src;
  logic [num_src-1:0] one_hot;
  int                 errs = 0;
  int                 errs_at_start = 0;
  int                 tests = 0;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp_val);
    if (got !== exp_val)
    begin
      errs++;
      $display("ERR %s: got %h exp %h", name, got, exp_val);
    end
  endtask

  // Commands are queued in the order the arbiter should grant them
  task automatic expect_cmd(input src_id_t src, input uce_resp_s resp);
    grant_q.push_back(src);
    resp_q.push_back('{src: src, resp: resp});
  endtask

  function automatic int pending();
    return grant_q.size() + resp_q.size();
  endfunction

  function automatic int error_count();
    return errs;
  endfunction

  task automatic start_test();
    errs_at_start = errs;
  endtask

  task automatic end_test(input string label);
    tests++;
    if (errs == errs_at_start)
      $display("%s: ok", label);
    else
      $display("%s: %0d mismatches", label, errs - errs_at_start);
  endtask

  task automatic check_outputs(input cfg_bus_s exp_cfg, input logic exp_sw);
    compare("cfg_bus_o", 64'(cfg_bus_i), 64'(exp_cfg));
    compare("software_irq_o", 64'(software_irq_i), 64'(exp_sw));
  endtask

  task automatic check_reset();
    compare("timer_irq_o", 64'(timer_irq_i), 64'h0);
    compare("src_cmd_yumi_o", 64'(yumi_i), 64'h0);
    compare("src_resp_v_o", 64'(resp_v_i), 64'h0);
    check_outputs('{freeze: 1'b1, core_id: '0}, 1'b0);
  endtask

  task automatic report_counts();
    $display("tests %0d, errors %0d", tests, errs);
  endtask

  always @(negedge clk_i)
  begin
    if (|yumi_i)
    begin
      if (grant_q.size() == 0)
      begin
        errs++;
        $display("a source was granted while no command was waiting");
      end
      else
      begin
        cur_src = grant_q.pop_front();
        one_hot = '0;
        one_hot[cur_src] = 1'b1;
        compare("src_cmd_yumi_o", 64'(yumi_i), 64'(one_hot));
      end
    end
    if (|(resp_v_i & resp_ready_and_i))
    begin
      if (resp_q.size() == 0)
      begin
        errs++;
        $display("a response arrived with no command outstanding");
      end
      else
      begin
        cur = resp_q.pop_front();
        one_hot = '0;
        one_hot[cur.src] = 1'b1;
        // The other source must stay quiet
        compare("src_resp_v_o", 64'(resp_v_i), 64'(one_hot));
        compare("src_resp_o.op", 64'(resp_i.op), 64'(cur.resp.op));
        compare("src_resp_o.addr", 64'(resp_i.addr), 64'(cur.resp.addr));
        compare("src_resp_o.data", resp_i.data, cur.resp.data);
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_top
  import uce_fabric_pkg::*;
();

  localparam int num_stim       = 20;
  localparam int grant_wait_max = 30;
  localparam int resp_wait_max  = 40;
  localparam int irq_wait_max   = 64;

  typedef struct packed {
    logic    pair;
    logic    wait_timer;
    src_id_t src;
    uce_op_e op;
    paddr_t  addr;
    dword_t  wdata;
    dword_t  rdata;
  } stim_s;

  logic                    clk_i;
  logic                    arst_n_i;
  uce_cmd_s  [num_src-1:0] src_cmd_i;
  logic      [num_src-1:0] src_cmd_v_i;
  logic      [num_src-1:0] src_cmd_yumi_o;
  uce_resp_s               src_resp_o;
  logic      [num_src-1:0] src_resp_v_o;
  logic      [num_src-1:0] src_resp_ready_and_i;
  uce_cmd_s                mem_cmd_o;
  logic                    mem_cmd_v_o;
  logic                    mem_cmd_ready_and_i;
  uce_resp_s               mem_resp_i;
  logic                    mem_resp_v_i;
  logic                    mem_resp_ready_and_o;
  cfg_bus_s                cfg_bus_o;
  logic                    timer_irq_o;
  logic                    software_irq_o;

  stim_s    stim [num_stim];
  dword_t   mem [paddr_t];
  int       seed = 54;
  logic     hung = 1'b0;
  src_id_t  last_src = 1'b1;
  cfg_bus_s exp_cfg;
  logic     exp_msip;

  uce_unicore_lite dut0 (.*);

  tb_checker chk0
  (
    .clk_i            (clk_i),
    .yumi_i           (src_cmd_yumi_o),
    .resp_i           (src_resp_o),
    .resp_v_i         (src_resp_v_o),
    .resp_ready_and_i (src_resp_ready_and_i),
    .cfg_bus_i        (cfg_bus_o),
    .timer_irq_i      (timer_irq_o),
    .software_irq_i   (software_irq_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic stim_s entry(input logic pair, input logic tmr, input src_id_t src,
                                  input uce_op_e op, input paddr_t addr,
                                  input dword_t wdata, input dword_t rdata);
    return '{pair: pair, wait_timer: tmr, src: src, op: op, addr: addr,
             wdata: wdata, rdata: rdata};
  endfunction

  function automatic uce_resp_s resp_for(input stim_s e);
    return '{op: e.op, addr: e.addr, data: (e.op == write) ? '0 : e.rdata};
  endfunction

  // Register model for the cfg bus and msip
  task automatic track_regs(input stim_s e);
    dev_off_t off;
    dev_id_t  dev;
    off = e.addr[15:0];
    dev = e.addr[19:16];
    if ((e.op == write) && (e.addr < dram_base_addr))
    begin
      if ((dev == cfg_dev) && (off == cfg_freeze_off))
        exp_cfg.freeze = e.wdata[0];
      if ((dev == cfg_dev) && (off == cfg_core_id_off))
        exp_cfg.core_id = e.wdata[7:0];
      if ((dev == clint_dev) && (off == clint_msip_off))
        exp_msip = e.wdata[0];
    end
  endtask

  task automatic await_grants(input logic [num_src-1:0] mask);
    logic [num_src-1:0] left;
    logic [num_src-1:0] taken;
    int                 n;
    left = mask;
    n = 0;
    while ((left != '0) && (n < grant_wait_max))
    begin
      @(negedge clk_i);
      taken = left & src_cmd_yumi_o;
      @(posedge clk_i);
      #1;
      src_cmd_v_i = src_cmd_v_i & ~taken;
      left = left & ~taken;
      n++;
    end
    if (left != '0)
    begin
      hung = 1'b1;
      $display("timeout: no grant for sources %b", left);
    end
  endtask

  task automatic await_responses();
    int n;
    n = 0;
    while ((chk0.pending() != 0) && (n < resp_wait_max))
    begin
      @(posedge clk_i);
      n++;
    end
    if (chk0.pending() != 0)
    begin
      hung = 1'b1;
      $display("timeout: a response never came back");
    end
  endtask

  task automatic await_timer_irq();
    int n;
    n = 0;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (!timer_irq_o && (n < irq_wait_max));
    if (!timer_irq_o)
    begin
      hung = 1'b1;
      $display("timeout: timer interrupt did not rise");
    end
  endtask

  task automatic apply(input int first, input int count);
    int                 a;
    int                 b;
    logic [num_src-1:0] mask;
    mask = '0;
    a = first;
    b = first + count - 1;
    // Round robin serves the source granted last in second place
    if ((count == 2) && (stim[first].src == last_src))
    begin
      a = first + 1;
      b = first;
    end
    chk0.start_test();
    @(posedge clk_i);
    #1;
    for (int k = first; k < first + count; k++)
    begin
      src_cmd_i[stim[k].src] = '{op: stim[k].op, addr: stim[k].addr, data: stim[k].wdata};
      src_cmd_v_i[stim[k].src] = 1'b1;
      mask[stim[k].src] = 1'b1;
      track_regs(stim[k]);
    end
    chk0.expect_cmd(stim[a].src, resp_for(stim[a]));
    if (count == 2)
      chk0.expect_cmd(stim[b].src, resp_for(stim[b]));
    last_src = stim[b].src;
    await_grants(mask);
    if (!hung)
      await_responses();
    if (!hung && stim[b].wait_timer)
      await_timer_irq();
    if (!hung)
    begin
      @(negedge clk_i);
      chk0.check_outputs(exp_cfg, exp_msip);
      chk0.end_test($sformatf("entry %0d, %0d command(s)", first, count));
    end
  endtask

  // Memory with a random response delay of 0 to 5 cycles
  initial
  begin : mem_model
    uce_cmd_s req;
    int       delay;
    int       n;
    mem_cmd_ready_and_i = 1'b1;
    mem_resp_v_i = 1'b0;
    mem_resp_i = '0;
    forever
    begin
      @(negedge clk_i);
      if (mem_cmd_v_o && mem_cmd_ready_and_i)
      begin
        req = mem_cmd_o;
        delay = ($random(seed) & 32'h7fff_ffff) % 6;
        if (req.op == write)
          mem[req.addr] = req.data;
        @(posedge clk_i);
        repeat (delay) @(posedge clk_i);
        #1;
        mem_resp_i.op = req.op;
        mem_resp_i.addr = req.addr;
        mem_resp_i.data = '0;
        if ((req.op == read) && mem.exists(req.addr))
          mem_resp_i.data = mem[req.addr];
        mem_resp_v_i = 1'b1;
        n = 0;
        do
        begin
          @(negedge clk_i);
          n++;
        end
        while (!mem_resp_ready_and_o && (n < resp_wait_max));
        if (!mem_resp_ready_and_o)
        begin
          hung = 1'b1;
          $display("timeout: memory response was never taken");
        end
        @(posedge clk_i);
        #1;
        mem_resp_v_i = 1'b0;
      end
    end
  end

  initial
  begin
    int i;
    arst_n_i = 1'b0;
    src_cmd_i = '0;
    src_cmd_v_i = '0;
    src_resp_ready_and_i = '1;
    exp_cfg = '{freeze: 1'b1, core_id: '0};
    exp_msip = 1'b0;

    stim[0]  = entry(1'b0, 1'b0, 1'b0, write, 24'h80_0100, 64'hDEAD_BEEF_0123_4567, '0);
    stim[1]  = entry(1'b0, 1'b0, 1'b1, read,  24'h80_0100, '0, 64'hDEAD_BEEF_0123_4567);
    stim[2]  = entry(1'b0, 1'b0, 1'b1, write, 24'h03_0040, 64'h0000_1111_2222_3333, '0);
    stim[3]  = entry(1'b0, 1'b0, 1'b0, read,  24'h03_0040, '0, 64'h0000_1111_2222_3333);
    stim[4]  = entry(1'b0, 1'b0, 1'b0, read,  24'h80_0200, '0, '0);
    stim[5]  = entry(1'b0, 1'b0, 1'b0, write, 24'h02_0000, '0, '0);
    stim[6]  = entry(1'b0, 1'b0, 1'b1, write, 24'h02_0008, 64'h5A, '0);
    stim[7]  = entry(1'b0, 1'b0, 1'b0, read,  24'h02_0000, '0, '0);
    stim[8]  = entry(1'b0, 1'b0, 1'b1, read,  24'h02_0008, '0, 64'h5A);
    stim[9]  = entry(1'b0, 1'b0, 1'b0, write, 24'h01_0000, 64'h1, '0);
    stim[10] = entry(1'b0, 1'b0, 1'b1, read,  24'h01_0000, '0, 64'h1);
    stim[11] = entry(1'b0, 1'b1, 1'b0, write, 24'h01_4000, 64'h40, '0);
    stim[12] = entry(1'b0, 1'b0, 1'b1, read,  24'h01_4000, '0, 64'h40);
    // Device 7 is unmapped and answered by loopback
    stim[13] = entry(1'b0, 1'b0, 1'b0, write, 24'h07_0000, 64'hFFFF, '0);
    stim[14] = entry(1'b0, 1'b0, 1'b1, read,  24'h07_0000, '0, '0);
    stim[15] = entry(1'b1, 1'b0, 1'b0, read,  24'h80_0100, '0, 64'hDEAD_BEEF_0123_4567);
    stim[16] = entry(1'b0, 1'b0, 1'b1, read,  24'h02_0008, '0, 64'h5A);
    stim[17] = entry(1'b0, 1'b0, 1'b0, write, 24'h80_0300, 64'h0123_4567_89AB_CDEF, '0);
    stim[18] = entry(1'b1, 1'b0, 1'b0, read,  24'h80_0300, '0, 64'h0123_4567_89AB_CDEF);
    stim[19] = entry(1'b0, 1'b0, 1'b1, read,  24'h01_0000, '0, 64'h1);

    repeat (8) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    chk0.start_test();
    @(negedge clk_i);
    chk0.check_reset();
    chk0.end_test("reset");

    i = 0;
    while ((i < num_stim) && !hung)
    begin
      if (stim[i].pair)
      begin
        apply(i, 2);
        i = i + 2;
      end
      else
      begin
        apply(i, 1);
        i = i + 1;
      end
    end

    chk0.report_counts();
    if (!hung && (chk0.error_count() == 0))
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/uce_fabric_pkg.sv
rtl/uce_cmd_arbiter.sv
rtl/uce_cfg_regs.sv
rtl/uce_clint.sv
rtl/uce_unicore_lite.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -Mdir obj_dir -o tb_sim -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
  exit 0
fi
exit 1
